// File: verilog/autotest_pkg.sv
package autotest_pkg;

  typedef logic [63:0] block_t;
  typedef logic [79:0] key_t;
  typedef logic [63:0] cycles_t;
  typedef logic [8:0]  offset_t;

  // parsed test vector as read from one SD block
  typedef struct packed {
    logic [31:0] signature;
    block_t      block;
    key_t        key;
    logic        decrypt;
    block_t      expected;
  } test_vector_t;

  typedef struct packed {
    block_t block;
    key_t   key;
    logic   decrypt;
  } uut_in_t;

  typedef struct packed {
    block_t block;
    logic   end_enc;
    logic   end_dec;
  } uut_out_t;

  // byte offsets inside a block, signature is stored msb first
  localparam offset_t SIG_OFS    = 9'd0;
  localparam offset_t BLOCK_OFS  = 9'd4;
  localparam offset_t KEY_OFS    = 9'd12;
  localparam offset_t MODE_OFS   = 9'd22;
  localparam offset_t EXP_OFS    = 9'd23;
  localparam offset_t RESULT_OFS = 9'd31;
  localparam offset_t CYCLES_OFS = 9'd39;

  localparam logic [31:0] VECTOR_SIGNATURE = 32'hAABB_CCDD;

endpackage

// File: verilog/sd_pkg.sv
package sd_pkg;

  localparam int BLOCK_BYTES = 512;

  typedef logic [31:0] block_addr_t;

  // request levels towards the SD/SPI host
  typedef struct packed {
    logic        rst;
    logic        r_block;
    logic        r_byte;
    logic        w_block;
    logic        w_byte;
    block_addr_t addr;
    logic [7:0]  wdata;
  } sd_cmd_t;

  typedef struct packed {
    logic       busy;
    logic [7:0] rdata;
    logic       err;
  } sd_rsp_t;

endpackage

// File: verilog/vector_field_reg.sv
module vector_field_reg #(
  parameter type field_t = logic [63:0]
) (
  input  logic                                 clk,
  input  logic                                 clear_i,
  input  logic                                 we_i,
  input  logic [$clog2($bits(field_t)/8)-1:0]  lane_i,
  input  logic [7:0]                           byte_i,
  output field_t                               value_o
);

  localparam int LANES = $bits(field_t) / 8;

  // lane 0 holds the least significant byte
  logic [LANES-1:0][7:0] bytes_q;

  always_ff @(posedge clk) begin
    if (clear_i) begin
      bytes_q <= '0;
    end else if (we_i) begin
      bytes_q[lane_i] <= byte_i;
    end
  end

  assign value_o = field_t'(bytes_q);

endmodule

// File: verilog/autotest_ctrl.sv
module autotest_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic sd_busy_i,
  input  logic xfer_done_i,
  input  logic sig_ok_i,
  input  logic run_done_i,
  input  logic mismatch_i,
  output logic sd_rst_o,
  output logic start_read_o,
  output logic start_write_o,
  output logic next_block_o,
  output logic clear_vector_o,
  output logic run_o,
  output logic halted_o
);

  typedef enum logic [3:0] {
    S_SD_RST,
    S_SD_WAIT,
    S_LOAD,
    S_READ,
    S_CHECK,
    S_RUN,
    S_DECIDE,
    S_WRITE,
    S_ADVANCE,
    S_HALT
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   mismatch_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_SD_RST;
    end else begin
      state_q <= state_d;
    end
  end

  // result of the last run, needed one step later
  always_ff @(posedge clk) begin
    if (rst) begin
      mismatch_q <= 1'b0;
    end else if (run_done_i) begin
      mismatch_q <= mismatch_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_SD_RST: begin
        if (sd_busy_i) begin
          state_d = S_SD_WAIT;
        end
      end
      S_SD_WAIT: begin
        if (!sd_busy_i) begin
          state_d = S_LOAD;
        end
      end
      S_LOAD: begin
        state_d = S_READ;
      end
      S_READ: begin
        if (xfer_done_i) begin
          state_d = S_CHECK;
        end
      end
      S_CHECK: begin
        state_d = sig_ok_i ? S_RUN : S_HALT;
      end
      S_RUN: begin
        if (run_done_i) begin
          state_d = S_DECIDE;
        end
      end
      S_DECIDE: begin
        state_d = mismatch_q ? S_WRITE : S_ADVANCE;
      end
      S_WRITE: begin
        if (xfer_done_i) begin
          state_d = S_ADVANCE;
        end
      end
      S_ADVANCE: begin
        state_d = S_LOAD;
      end
      default: begin
        state_d = S_HALT;
      end
    endcase
  end

  // host reset request stays low while the design is in reset
  assign sd_rst_o       = (state_q == S_SD_RST) && !rst;
  assign clear_vector_o = (state_q == S_LOAD);
  assign start_read_o   = (state_q == S_LOAD);
  assign run_o          = (state_q == S_CHECK) && sig_ok_i;
  assign start_write_o  = (state_q == S_DECIDE) && mismatch_q;
  assign next_block_o   = (state_q == S_ADVANCE);
  assign halted_o       = (state_q == S_HALT);

endmodule

// File: verilog/sd_block_sequencer.sv
module sd_block_sequencer
  import sd_pkg::*;
#(
  parameter block_addr_t START_BLOCK = 32'h0010_0000
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start_read_i,
  input  logic                           start_write_i,
  input  logic                           next_block_i,
  input  sd_rsp_t                        sd_rsp_i,
  input  logic [7:0]                     wr_byte_i,
  output sd_cmd_t                        sd_req_o,
  output logic                           rd_strobe_o,
  output logic [$clog2(BLOCK_BYTES)-1:0] offset_o,
  output logic [7:0]                     rd_byte_o,
  output logic                           xfer_done_o
);

  localparam int OFS_W = $clog2(BLOCK_BYTES);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT
  } state_t;

  state_t            state_q;
  logic              write_q;
  logic [OFS_W-1:0]  offset_q;
  block_addr_t       addr_q;
  logic              byte_done;
  logic              last_byte;

  // busy falling ends the current byte
  assign byte_done = (state_q == S_WAIT) && !sd_rsp_i.busy;
  assign last_byte = (offset_q == OFS_W'(BLOCK_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      write_q     <= 1'b0;
      offset_q    <= '0;
      xfer_done_o <= 1'b0;
    end else begin
      xfer_done_o <= byte_done && last_byte;
      case (state_q)
        S_IDLE: begin
          if (start_read_i || start_write_i) begin
            write_q  <= start_write_i;
            offset_q <= '0;
            state_q  <= S_REQ;
          end
        end
        S_REQ: begin
          if (sd_rsp_i.busy) begin
            state_q <= S_WAIT;
          end
        end
        default: begin
          if (byte_done) begin
            offset_q <= offset_q + 1'b1;
            state_q  <= last_byte ? S_IDLE : S_REQ;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= START_BLOCK;
    end else if (next_block_i) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  always_comb begin
    sd_req_o         = '0;
    sd_req_o.addr    = addr_q;
    sd_req_o.wdata   = wr_byte_i;
    sd_req_o.r_block = (state_q != S_IDLE) && !write_q;
    sd_req_o.w_block = (state_q != S_IDLE) && write_q;
    sd_req_o.r_byte  = (state_q == S_REQ) && !write_q;
    sd_req_o.w_byte  = (state_q == S_REQ) && write_q;
  end

  assign rd_strobe_o = byte_done && !write_q;
  assign offset_o    = offset_q;
  assign rd_byte_o   = sd_rsp_i.rdata;

endmodule

// File: verilog/vector_loader.sv
module vector_loader
  import autotest_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         clear_i,
  input  logic         rd_strobe_i,
  input  offset_t      offset_i,
  input  logic [7:0]   rd_byte_i,
  output test_vector_t vector_o,
  output logic         sig_ok_o
);

  logic [3:0][7:0] sig_q;
  logic            mode_q;
  offset_t         rel_sig;
  offset_t         rel_blk;
  offset_t         rel_key;
  offset_t         rel_exp;
  logic            in_sig;
  logic            in_blk;
  logic            in_key;
  logic            in_mode;
  logic            in_exp;
  block_t          blk_val;
  key_t            key_val;
  block_t          exp_val;

  assign rel_sig = offset_i - SIG_OFS;
  assign rel_blk = offset_i - BLOCK_OFS;
  assign rel_key = offset_i - KEY_OFS;
  assign rel_exp = offset_i - EXP_OFS;

  assign in_sig  = (offset_i < BLOCK_OFS);
  assign in_blk  = (offset_i >= BLOCK_OFS) && (offset_i < KEY_OFS);
  assign in_key  = (offset_i >= KEY_OFS) && (offset_i < MODE_OFS);
  assign in_mode = (offset_i == MODE_OFS);
  assign in_exp  = (offset_i >= EXP_OFS) && (offset_i < RESULT_OFS);

  // signature arrives msb first
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      sig_q  <= '0;
      mode_q <= 1'b0;
    end else if (rd_strobe_i) begin
      if (in_sig) begin
        sig_q[2'd3 - rel_sig[1:0]] <= rd_byte_i;
      end
      if (in_mode) begin
        mode_q <= rd_byte_i[0];
      end
    end
  end

  vector_field_reg #(.field_t(block_t)) u_block (
    .clk     (clk),
    .clear_i (clear_i),
    .we_i    (rd_strobe_i && in_blk),
    .lane_i  (rel_blk[2:0]),
    .byte_i  (rd_byte_i),
    .value_o (blk_val)
  );

  vector_field_reg #(.field_t(key_t)) u_key (
    .clk     (clk),
    .clear_i (clear_i),
    .we_i    (rd_strobe_i && in_key),
    .lane_i  (rel_key[3:0]),
    .byte_i  (rd_byte_i),
    .value_o (key_val)
  );

  vector_field_reg #(.field_t(block_t)) u_expected (
    .clk     (clk),
    .clear_i (clear_i),
    .we_i    (rd_strobe_i && in_exp),
    .lane_i  (rel_exp[2:0]),
    .byte_i  (rd_byte_i),
    .value_o (exp_val)
  );

  assign vector_o = '{
    signature: sig_q,
    block:     blk_val,
    key:       key_val,
    decrypt:   mode_q,
    expected:  exp_val
  };

  assign sig_ok_o = (sig_q == VECTOR_SIGNATURE);

endmodule

// File: verilog/uut_runner.sv
module uut_runner
  import autotest_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         run_i,
  input  test_vector_t vector_i,
  input  uut_out_t     uut_out_i,
  output uut_in_t      uut_in_o,
  output logic         uut_rst_o,
  output block_t       result_o,
  output cycles_t      cycles_o,
  output logic         done_o,
  output logic         mismatch_o,
  output logic [31:0]  error_count_o
);

  logic    uut_rst_q;
  logic    captured_q;
  logic    running;
  logic    end_flag;
  block_t  result_q;
  cycles_t cycles_q;

  assign uut_in_o = '{
    block:   vector_i.block,
    key:     vector_i.key,
    decrypt: vector_i.decrypt
  };

  // only the flag of the selected mode ends the run
  assign end_flag = vector_i.decrypt ? uut_out_i.end_dec : uut_out_i.end_enc;
  assign running  = !uut_rst_q && !captured_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      uut_rst_q     <= 1'b1;
      captured_q    <= 1'b0;
      done_o        <= 1'b0;
      mismatch_o    <= 1'b0;
      error_count_o <= '0;
    end else begin
      done_o <= 1'b0;
      if (run_i) begin
        uut_rst_q <= 1'b0;
      end else if (running && end_flag) begin
        captured_q <= 1'b1;
      end else if (captured_q) begin
        captured_q <= 1'b0;
        uut_rst_q  <= 1'b1;
        done_o     <= 1'b1;
        mismatch_o <= (result_q != vector_i.expected);
        if (result_q != vector_i.expected) begin
          error_count_o <= error_count_o + 1'b1;
        end
      end
    end
  end

  // count freezes at the capture edge
  always_ff @(posedge clk) begin
    if (run_i) begin
      cycles_q <= '0;
    end else if (running && !end_flag) begin
      cycles_q <= cycles_q + 1'b1;
    end
    if (running && end_flag) begin
      result_q <= uut_out_i.block;
    end
  end

  assign uut_rst_o = uut_rst_q;
  assign result_o  = result_q;
  assign cycles_o  = cycles_q;

endmodule

// File: verilog/report_serializer.sv
module report_serializer
  import autotest_pkg::*;
(
  input  offset_t      offset_i,
  input  test_vector_t vector_i,
  input  block_t       result_i,
  input  cycles_t      cycles_i,
  output logic [7:0]   byte_o
);

  localparam offset_t CYCLES_END = CYCLES_OFS + offset_t'($bits(cycles_t) / 8);

  logic [3:0][7:0] sig_b;
  logic [7:0][7:0] blk_b;
  logic [9:0][7:0] key_b;
  logic [7:0][7:0] exp_b;
  logic [7:0][7:0] res_b;
  logic [7:0][7:0] cyc_b;
  offset_t         rel;

  assign sig_b = vector_i.signature;
  assign blk_b = vector_i.block;
  assign key_b = vector_i.key;
  assign exp_b = vector_i.expected;
  assign res_b = result_i;
  assign cyc_b = cycles_i;

  always_comb begin
    rel    = '0;
    byte_o = 8'h00;
    if (offset_i < BLOCK_OFS) begin
      rel    = offset_i - SIG_OFS;
      byte_o = sig_b[2'd3 - rel[1:0]];
    end else if (offset_i < KEY_OFS) begin
      rel    = offset_i - BLOCK_OFS;
      byte_o = blk_b[rel[2:0]];
    end else if (offset_i < MODE_OFS) begin
      rel    = offset_i - KEY_OFS;
      byte_o = key_b[rel[3:0]];
    end else if (offset_i == MODE_OFS) begin
      byte_o = {7'b0, vector_i.decrypt};
    end else if (offset_i < RESULT_OFS) begin
      rel    = offset_i - EXP_OFS;
      byte_o = exp_b[rel[2:0]];
    end else if (offset_i < CYCLES_OFS) begin
      rel    = offset_i - RESULT_OFS;
      byte_o = res_b[rel[2:0]];
    end else if (offset_i < CYCLES_END) begin
      rel    = offset_i - CYCLES_OFS;
      byte_o = cyc_b[rel[2:0]];
    end
  end

endmodule

// File: verilog/autotest_top.sv
module autotest_top
  import autotest_pkg::*;
  import sd_pkg::*;
#(
  parameter block_addr_t START_BLOCK = 32'h0010_0000
) (
  input  logic        clk,
  input  logic        rst,
  input  sd_rsp_t     sd_rsp_i,
  input  uut_out_t    uut_out_i,
  output sd_cmd_t     sd_cmd_o,
  output uut_in_t     uut_in_o,
  output logic        uut_rst_o,
  output logic [31:0] error_count_o,
  output logic        halted_o
);

  logic         sd_rst;
  logic         start_read;
  logic         start_write;
  logic         next_block;
  logic         clear_vector;
  logic         xfer_done;
  logic         sig_ok;
  logic         run;
  logic         run_done;
  logic         mismatch;
  logic         rd_strobe;
  offset_t      offset;
  logic [7:0]   rd_byte;
  logic [7:0]   wr_byte;
  sd_cmd_t      sd_req;
  test_vector_t vector;
  block_t       result;
  cycles_t      cycles;

  // host reset comes from the controller, everything else from the sequencer
  assign sd_cmd_o = '{
    rst:     sd_rst,
    r_block: sd_req.r_block,
    r_byte:  sd_req.r_byte,
    w_block: sd_req.w_block,
    w_byte:  sd_req.w_byte,
    addr:    sd_req.addr,
    wdata:   sd_req.wdata
  };

  autotest_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .sd_busy_i      (sd_rsp_i.busy),
    .xfer_done_i    (xfer_done),
    .sig_ok_i       (sig_ok),
    .run_done_i     (run_done),
    .mismatch_i     (mismatch),
    .sd_rst_o       (sd_rst),
    .start_read_o   (start_read),
    .start_write_o  (start_write),
    .next_block_o   (next_block),
    .clear_vector_o (clear_vector),
    .run_o          (run),
    .halted_o       (halted_o)
  );

  sd_block_sequencer #(
    .START_BLOCK (START_BLOCK)
  ) u_sd_seq (
    .clk           (clk),
    .rst           (rst),
    .start_read_i  (start_read),
    .start_write_i (start_write),
    .next_block_i  (next_block),
    .sd_rsp_i      (sd_rsp_i),
    .wr_byte_i     (wr_byte),
    .sd_req_o      (sd_req),
    .rd_strobe_o   (rd_strobe),
    .offset_o      (offset),
    .rd_byte_o     (rd_byte),
    .xfer_done_o   (xfer_done)
  );

  vector_loader u_loader (
    .clk         (clk),
    .rst         (rst),
    .clear_i     (clear_vector),
    .rd_strobe_i (rd_strobe),
    .offset_i    (offset),
    .rd_byte_i   (rd_byte),
    .vector_o    (vector),
    .sig_ok_o    (sig_ok)
  );

  uut_runner u_runner (
    .clk           (clk),
    .rst           (rst),
    .run_i         (run),
    .vector_i      (vector),
    .uut_out_i     (uut_out_i),
    .uut_in_o      (uut_in_o),
    .uut_rst_o     (uut_rst_o),
    .result_o      (result),
    .cycles_o      (cycles),
    .done_o        (run_done),
    .mismatch_o    (mismatch),
    .error_count_o (error_count_o)
  );

  report_serializer u_report (
    .offset_i (offset),
    .vector_i (vector),
    .result_i (result),
    .cycles_i (cycles),
    .byte_o   (wr_byte)
  );

endmodule

// File: sim/autotest_checker.sv
module autotest_checker
  import sd_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input sd_cmd_t sd_cmd_i,
  input logic    uut_rst_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic blk_active;

  assign blk_active = sd_cmd_i.r_block || sd_cmd_i.w_block;

  // host reset and block requests never overlap
  one_block_req: assert property (
    @(posedge clk) disable iff (rst) $onehot0({sd_cmd_i.rst, sd_cmd_i.r_block, sd_cmd_i.w_block})
  ) else $error("more than one SD request active together");

  addr_stable: assert property (
    @(posedge clk) disable iff (rst) (blk_active && $past(blk_active)) |-> $stable(sd_cmd_i.addr)
  ) else $error("block address changed during a block request");

  // core held in reset while a vector is loaded
  rst_during_read: assert property (
    @(posedge clk) disable iff (rst) sd_cmd_i.r_block |-> uut_rst_i
  ) else $error("core out of reset during a block read");

endmodule

// File: sim/autotest_tb.sv
module autotest_tb
  import autotest_pkg::*;
  import sd_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam block_addr_t START_BLOCK = 32'h0010_0000;
  localparam int NVEC   = 6;
  localparam int NBLK   = NVEC + 1;
  localparam int MAXD   = 4;
  localparam int MAXLAT = 20;
  localparam int LIMIT  = NBLK * 2 * BLOCK_BYTES * (MAXD + 4) + NBLK * MAXLAT + 1000;

  logic        clk;
  logic        rst;
  sd_rsp_t     sd_rsp;
  uut_out_t    uut_out;
  sd_cmd_t     sd_cmd;
  uut_in_t     uut_in;
  logic        uut_rst;
  logic [31:0] error_count;
  logic        halted;

  logic [7:0] mem [NBLK*BLOCK_BYTES];
  logic [7:0] orig [NBLK*BLOCK_BYTES];
  logic [7:0] exp_rep [BLOCK_BYTES];
  block_t     vblk [NVEC];
  key_t       vkey [NVEC];
  logic       vdec [NVEC];
  block_t     vexp [NVEC];
  logic       vbad [NVEC];
  int         bytes_written [NBLK];
  int         reads;
  int         cyc_cnt;
  int         n_bad;
  // SD host model state
  logic       in_op;
  int         busy_left;
  int         byte_ofs;
  int         cur_blk;
  logic       r_prev;
  logic       w_prev;
  // core model state
  int         lat;
  int         lat_cnt;
  int         low_cnt;
  int         obs_cycles;
  logic       flag_seen;

  autotest_top #(.START_BLOCK(START_BLOCK)) DUT (
    .clk           (clk),
    .rst           (rst),
    .sd_rsp_i      (sd_rsp),
    .uut_out_i     (uut_out),
    .sd_cmd_o      (sd_cmd),
    .uut_in_o      (uut_in),
    .uut_rst_o     (uut_rst),
    .error_count_o (error_count),
    .halted_o      (halted)
  );

  bind autotest_top autotest_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .sd_cmd_i  (sd_cmd_o),
    .uut_rst_i (uut_rst_o)
  );

  task automatic abort_run(input string msg);
    $display("%s at %0t", msg, $time);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  function automatic block_t cipher_model(input block_t b, input key_t k, input logic dec);
    block_t x;
    x = b ^ k[63:0];
    return dec ? {x[62:0], x[63]} : x;
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a ^ (a >> 8) ^ (a >> 16) ^ 8'h5a);
  endfunction

  // expected write-back for vector v
  function automatic void build_report(input int v);
    block_t res;
    res = cipher_model(vblk[v], vkey[v], vdec[v]);
    for (int i = 0; i < BLOCK_BYTES; i++) exp_rep[i] = 8'h00;
    for (int i = 0; i < 4; i++) exp_rep[i] = VECTOR_SIGNATURE[31-8*i -: 8];
    for (int i = 0; i < 8; i++) begin
      exp_rep[4+i]  = vblk[v][8*i +: 8];
      exp_rep[23+i] = vexp[v][8*i +: 8];
      exp_rep[31+i] = res[8*i +: 8];
      exp_rep[39+i] = 8'(obs_cycles >> (8*i));
    end
    for (int i = 0; i < 10; i++) exp_rep[12+i] = vkey[v][8*i +: 8];
    exp_rep[22] = {7'b0, vdec[v]};
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt > LIMIT) abort_run("timeout, the sequencer never halted");
  end

  // behavioral SD host over the block array
  always @(posedge clk) begin
    if (rst) begin
      sd_rsp <= '0;
      in_op = 1'b0;
      r_prev = 1'b0;
      w_prev = 1'b0;
    end else begin
      if (halted) begin
        assert (!(sd_cmd.rst || sd_cmd.r_block || sd_cmd.w_block))
          else abort_run("SD request seen after halt");
      end
      if ((sd_cmd.r_block && !r_prev) || (sd_cmd.w_block && !w_prev)) begin
        cur_blk = int'(sd_cmd.addr - START_BLOCK);
        byte_ofs = 0;
        assert (cur_blk >= 0 && cur_blk < NBLK) else abort_run("block address out of range");
        if (sd_cmd.r_block) begin
          assert (sd_cmd.addr == START_BLOCK + block_addr_t'(reads))
            else fail_value("sd_cmd.addr", 64'(sd_cmd.addr), 64'(START_BLOCK + reads));
          reads++;
        end else begin
          assert (cur_blk < NVEC && vbad[cur_blk])
            else abort_run("write-back of a matching vector");
          build_report(cur_blk);
        end
      end
      r_prev = sd_cmd.r_block;
      w_prev = sd_cmd.w_block;
      if (in_op) begin
        if (busy_left > 0) begin
          busy_left--;
        end else begin
          sd_rsp.busy <= 1'b0;
          in_op = 1'b0;
        end
      end else if (sd_cmd.rst || sd_cmd.r_byte || sd_cmd.w_byte) begin
        in_op = 1'b1;
        busy_left = int'($urandom_range(MAXD, 0));
        sd_rsp.busy <= 1'b1;
        if (sd_cmd.r_byte) begin
          sd_rsp.rdata <= mem[cur_blk*BLOCK_BYTES + byte_ofs];
          byte_ofs++;
        end else if (sd_cmd.w_byte) begin
          assert (sd_cmd.wdata == exp_rep[byte_ofs])
            else fail_value($sformatf("sd_cmd.wdata[%0d]", byte_ofs), 64'(sd_cmd.wdata),
                            64'(exp_rep[byte_ofs]));
          mem[cur_blk*BLOCK_BYTES + byte_ofs] = sd_cmd.wdata;
          bytes_written[cur_blk]++;
          byte_ofs++;
        end
      end
    end
  end

  // cipher core model, the wrong-mode flag pulses once early in every run
  always @(posedge clk) begin
    if (rst || uut_rst) begin
      uut_out <= '0;
      lat_cnt = 0;
      low_cnt = 0;
      flag_seen = 1'b0;
      lat = int'($urandom_range(MAXLAT, 2));
    end else begin
      if (!flag_seen) begin
        if (uut_in.decrypt ? uut_out.end_dec : uut_out.end_enc) begin
          obs_cycles = low_cnt;
          flag_seen = 1'b1;
        end else begin
          low_cnt++;
        end
      end
      lat_cnt++;
      uut_out.block <= cipher_model(uut_in.block, uut_in.key, uut_in.decrypt);
      uut_out.end_enc <= uut_in.decrypt ? (lat_cnt == 1) : (lat_cnt >= lat);
      uut_out.end_dec <= uut_in.decrypt ? (lat_cnt >= lat) : (lat_cnt == 1);
    end
  end

  initial begin
    int base;
    void'($urandom(32'h40139c64));
    rst = 1'b1;
    sd_rsp = '0;
    uut_out = '0;
    for (int a = 0; a < NBLK*BLOCK_BYTES; a++) mem[a] = fill_byte(a);
    for (int v = 0; v < NBLK; v++) begin
      base = v * BLOCK_BYTES;
      for (int i = 0; i < 4; i++) begin
        mem[base+i] = (v < NVEC) ? VECTOR_SIGNATURE[31-8*i -: 8] : 8'(8'hA0 + i);
      end
      if (v < NVEC) begin
        vblk[v] = {$urandom, $urandom};
        vkey[v] = {16'($urandom), $urandom, $urandom};
        vdec[v] = v[0];
        vbad[v] = (v == 1 || v == 4);
        vexp[v] = cipher_model(vblk[v], vkey[v], vdec[v]) ^ (vbad[v] ? 64'h0100_0000_0001 : 64'h0);
        for (int i = 0; i < 8; i++) mem[base+4+i] = vblk[v][8*i +: 8];
        for (int i = 0; i < 10; i++) mem[base+12+i] = vkey[v][8*i +: 8];
        mem[base+22] = {7'b0, vdec[v]};
        for (int i = 0; i < 8; i++) mem[base+23+i] = vexp[v][8*i +: 8];
        if (vbad[v]) n_bad++;
      end
    end
    for (int a = 0; a < NBLK*BLOCK_BYTES; a++) orig[a] = mem[a];

    repeat (9) @(posedge clk);
    @(negedge clk);
    assert (!(sd_cmd.rst || sd_cmd.r_block || sd_cmd.w_block ||
              sd_cmd.r_byte || sd_cmd.w_byte))
      else abort_run("SD request active during reset");
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!sd_cmd.r_block && !sd_cmd.w_block) else abort_run("block request during SD reset");
    assert (uut_rst == 1'b1) else fail_value("uut_rst_o", 64'(uut_rst), 64'd1);
    assert (error_count == 0) else fail_value("error_count_o", 64'(error_count), 64'd0);

    while (!halted) @(posedge clk);
    repeat (50) @(posedge clk);

    assert (error_count == 32'(n_bad))
      else fail_value("error_count_o", 64'(error_count), 64'(n_bad));
    assert (reads == NBLK) else fail_value("block reads", 64'(reads), 64'(NBLK));
    for (int v = 0; v < NVEC; v++) begin
      if (vbad[v]) begin
        assert (bytes_written[v] == BLOCK_BYTES)
          else fail_value("bytes written", 64'(bytes_written[v]), 64'(BLOCK_BYTES));
      end else begin
        for (int i = 0; i < BLOCK_BYTES; i++) begin
          assert (mem[v*BLOCK_BYTES+i] == orig[v*BLOCK_BYTES+i])
            else abort_run("a matching vector's SD block was changed");
        end
      end
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: autotest_top.f
verilog/autotest_pkg.sv
verilog/sd_pkg.sv
verilog/vector_field_reg.sv
verilog/autotest_ctrl.sv
verilog/sd_block_sequencer.sv
verilog/vector_loader.sv
verilog/uut_runner.sv
verilog/report_serializer.sv
verilog/autotest_top.sv
sim/autotest_checker.sv
sim/autotest_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module autotest_tb \
  -f autotest_top.f -o autotest_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/autotest_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q "TEST PASSED" sim.log; then
  exit 0
fi
exit 1
